// File: decode_stim.txt
# name inst we addr data | alu src_a src_b rd1 rd2 imm shamt dest flags wb_sel fwd_a fwd_b fwd_st | ctrl
# flags = reg_write mem_write mem_read out_en halt; ctrl = pc_en ifid_en idex_flush
reset C150 0 0 0000 5 0 0 0000 0000 0050 0 1 00000 2 0 0 0 110
reset D350 0 0 0000 5 0 0 0000 0000 0050 0 3 00000 2 0 0 0 110
reset E550 0 0 0000 5 0 0 0000 0000 0050 0 5 00000 2 0 0 0 110
reset F750 0 0 0000 5 0 0 0000 0000 0050 0 7 00000 2 0 0 0 110
wb CA50 1 1 1234 5 0 0 1234 0000 0050 0 2 00000 2 0 0 0 110
wb D350 1 3 BEEF 5 0 0 0000 BEEF 0050 0 3 00000 2 0 0 0 110
wb D950 0 0 0000 5 0 0 BEEF 1234 0050 0 1 00000 2 0 0 0 110
wb E550 1 5 0055 5 0 0 0000 0055 0050 0 5 00000 2 0 0 0 110
dec 1485 0 0 0000 0 0 1 0000 0000 FF85 5 2 10100 1 0 0 0 110
dec 5D10 0 0 0000 0 0 1 BEEF 0055 0010 0 5 01000 2 0 0 0 110
dec 867F 0 0 0000 0 3 1 0000 0000 007F F 6 10000 0 0 0 0 110
dec 8FF0 0 0 0000 0 0 1 1234 0000 FFF0 0 7 10000 0 0 0 0 110
dec 9D01 0 0 0000 5 0 1 BEEF 0055 0001 1 5 00000 2 0 0 0 110
dec CB00 0 0 0000 0 0 0 1234 BEEF 0000 0 3 10000 0 0 0 0 110
dec E583 0 0 0000 8 0 2 0000 0055 FF83 3 5 10000 0 0 0 0 110
dec C8D0 0 0 0000 D 3 0 1234 0000 FFD0 0 0 00010 2 0 0 0 110
dec D4F0 0 0 0000 F 3 3 0000 0000 FFF0 0 4 00001 2 0 0 0 110
fwd CA00 0 0 0000 0 0 0 1234 0000 0000 0 2 10000 0 0 0 0 110
fwd D300 0 0 0000 0 0 0 0000 BEEF 0000 0 3 10000 0 0 1 1 110
fwd D300 1 2 1234 0 0 0 1234 BEEF 0000 0 3 10000 0 1 2 2 110
fwd D500 1 3 D123 0 0 0 1234 0055 0000 0 5 10000 0 0 0 0 110
ldu 2102 0 0 0000 0 0 1 0000 1234 0002 2 4 10100 1 0 0 0 110
ldu E600 0 0 0000 0 0 0 0000 0000 0000 0 6 10000 0 0 0 0 001
ldu E600 1 4 A5A5 0 0 0 A5A5 0000 0000 0 6 10000 0 0 2 2 110
ldu 2A00 0 0 0000 0 0 1 0055 1234 0000 0 5 10100 1 0 0 0 110
ldu 6B04 0 0 0000 0 0 1 0055 D123 0004 4 3 01000 2 0 0 0 001
ldu 6B04 1 5 5A5A 0 0 1 5A5A D123 0004 4 3 01000 2 0 2 2 110
nowr CA50 0 0 0000 5 0 0 1234 1234 0050 0 2 00000 2 0 0 0 110
nowr D100 0 0 0000 0 0 0 1234 1234 0000 0 1 10000 0 0 0 0 110
nowr 7700 0 0 0000 0 0 1 0000 0000 0000 0 7 01000 2 0 0 0 110
nowr DF00 0 0 0000 0 0 0 D123 0000 0000 0 7 10000 0 0 0 0 110

// File: files.f
cpu_isa_pkg.sv
pipe_ctrl_pkg.sv
id_controller.sv
register_file.sv
hazard_unit.sv
forwarding_unit.sv
decode_stage.sv
tb_decode_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_decode_stage -f files.f -o sim_decode
./obj_dir/sim_decode | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
   echo "Simulation failed, see sim.log"
   exit 1
fi
echo "Simulation passed"

// File: tb_decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module tb_decode_stage;
   import cpu_isa_pkg::*;
   import pipe_ctrl_pkg::*;

   typedef struct packed {
      logic pc_en;
      logic ifid_en;
      logic idex_flush;
   } ctrl_lv_t;

   localparam word_t IDLE_MOV   = 16'hC060;   // MOV r0, r0
   localparam word_t RESET_INST = 16'hC050;   // CMP r0, r0
   localparam int    MAX_LINES  = 200;

   logic    clk;
   logic    rst_n;
   word_t   inst;
   wb_bus_t wb;
   id_ex_t  ex;
   logic    pc_en;
   logic    ifid_en;
   logic    idex_flush;
   int      ex_errors;
   int      ctrl_errors;
   logic    other_fail;

   decode_stage uut (
      .clk(clk), .rst_n(rst_n), .inst(inst), .wb(wb),
      .ex(ex), .pc_en(pc_en), .ifid_en(ifid_en), .idex_flush(idex_flush)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic check_ex(input logic [127:0] name, input id_ex_t exp, input id_ex_t act);
      if (act !== exp) begin
         ex_errors++;
         $display("ERR %0s ex expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_ctrl(input logic [127:0] name, input ctrl_lv_t exp,
                             input ctrl_lv_t act);
      if (act !== exp) begin
         ctrl_errors++;
         $display("ERR %0s ctrl expected %b actual %b", name, exp, act);
      end
   endtask

   task automatic run_idle(input int cycles);
      for (int i = 0; i < cycles; i++) begin
         @(negedge clk);
         inst = IDLE_MOV;
         wb   = '0;
      end
   endtask

   task automatic wait_reset_release(output logic ok);
      int n;
      n = 0;
      while (!(pc_en === 1'b1 && ifid_en === 1'b1 && idex_flush === 1'b0) && n < 20) begin
         @(negedge clk);
         n++;
      end
      ok = (n < 20);
      if (!ok) begin
         $display("Timed out waiting for the decode stage to leave reset");
      end
   endtask

   initial begin
      #5000;
      $display("Simulation time limit reached before the stimulus finished");
      $display("TEST RESULT: FAIL");
      $finish;
   end

   initial begin
      int           fd;
      int           n_read;
      int           n_iter;
      int           n_checked;
      int           seed_ret;
      logic         reset_ok;
      string        line;
      logic [127:0] name_v;
      logic [127:0] prev_v;
      logic [15:0]  v_inst;
      logic         v_we;
      logic [2:0]   v_addr;
      logic [15:0]  v_data;
      logic [3:0]   v_alu;
      logic [1:0]   v_sa;
      logic [1:0]   v_sb;
      logic [15:0]  v_rd1;
      logic [15:0]  v_rd2;
      logic [15:0]  v_imm;
      logic [3:0]   v_shamt;
      logic [2:0]   v_dest;
      logic [4:0]   v_flags;
      logic [1:0]   v_wbs;
      logic [1:0]   v_fa;
      logic [1:0]   v_fb;
      logic [1:0]   v_fs;
      logic [2:0]   v_ctrl;
      id_ex_t       exp_ex;
      ctrl_lv_t     act_ctrl;

      seed_ret    = $urandom(26);
      ex_errors   = 0;
      ctrl_errors = 0;
      other_fail  = 1'b0;
      n_checked   = 0;
      rst_n       = 1'b0;
      inst        = RESET_INST;    // Reads r0, writes nothing
      wb          = '0;
      prev_v      = '0;
      repeat (10) @(negedge clk);
      rst_n = 1'b1;
      wait_reset_release(reset_ok);
      if (!reset_ok) begin
         other_fail = 1'b1;
      end

      fd = $fopen("decode_stim.txt", "r");
      if (fd == 0) begin
         $display("Could not open decode_stim.txt");
         other_fail = 1'b1;
      end else begin
         n_iter = 0;
         while (!$feof(fd) && n_iter < MAX_LINES && !other_fail) begin
            n_iter++;
            n_read = $fgets(line, fd);
            if (n_read > 1 && line.getc(0) != "#") begin
               n_read = $sscanf(line,
                  "%s %h %h %h %h %h %h %h %h %h %h %h %h %b %h %h %h %h %b",
                  name_v, v_inst, v_we, v_addr, v_data, v_alu, v_sa, v_sb,
                  v_rd1, v_rd2, v_imm, v_shamt, v_dest, v_flags, v_wbs,
                  v_fa, v_fb, v_fs, v_ctrl);
               if (n_read != 19) begin
                  $display("Malformed line in decode_stim.txt: %s", line);
                  other_fail = 1'b1;
               end else begin
                  if (prev_v != '0 && name_v != prev_v) begin
                     run_idle(2 + int'($urandom % 3));   // Older entries retire
                  end
                  prev_v        = name_v;
                  exp_ex        = '0;
                  exp_ex.alu_op = alu_op_e'(v_alu);
                  exp_ex.src_a  = src_sel_e'(v_sa);
                  exp_ex.src_b  = src_sel_e'(v_sb);
                  exp_ex.rd1    = v_rd1;
                  exp_ex.rd2    = v_rd2;
                  exp_ex.imm    = v_imm;
                  exp_ex.shamt  = v_shamt;
                  exp_ex.dest   = v_dest;
                  {exp_ex.reg_write, exp_ex.mem_write, exp_ex.mem_read,
                   exp_ex.out_en, exp_ex.halt} = v_flags;
                  exp_ex.wb_sel = wb_sel_e'(v_wbs);
                  exp_ex.fwd_a  = fwd_sel_e'(v_fa);
                  exp_ex.fwd_b  = fwd_sel_e'(v_fb);
                  exp_ex.fwd_st = fwd_sel_e'(v_fs);

                  @(negedge clk);
                  inst    = v_inst;
                  wb.we   = v_we;
                  wb.addr = v_addr;
                  wb.data = v_data;
                  #1;                      // Just before the rising edge
                  act_ctrl = {pc_en, ifid_en, idex_flush};
                  check_ex(name_v, exp_ex, ex);
                  check_ctrl(name_v, ctrl_lv_t'(v_ctrl), act_ctrl);
                  n_checked++;
               end
            end
         end
         $fclose(fd);
      end

      if (n_checked == 0) begin
         $display("No stimulus lines were checked");
         other_fail = 1'b1;
      end
      $display("Errors: ex %0d, ctrl %0d, other %0d", ex_errors, ctrl_errors, other_fail);
      if (ex_errors == 0 && ctrl_errors == 0 && !other_fail) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
   input  logic                   clk,
   input  logic                   rst_n,
   input  cpu_isa_pkg::word_t     inst,
   input  pipe_ctrl_pkg::wb_bus_t wb,
   output pipe_ctrl_pkg::id_ex_t  ex,
   output logic                   pc_en,
   output logic                   ifid_en,
   output logic                   idex_flush
);
   import cpu_isa_pkg::*;
   import pipe_ctrl_pkg::*;

   alu_fmt_t        af;
   id_ex_t          ctl;
   logic            use_ra;
   logic            use_rb;
   word_t           rd1;
   word_t           rd2;
   logic            stall;
   sb_entry_t [7:0] sb;
   fwd_sel_e        fwd_a;
   fwd_sel_e        fwd_b;
   fwd_sel_e        fwd_st;

   assign af = alu_fmt_t'(inst);

   id_controller u_ctrl (.inst(inst), .ctl(ctl), .use_ra(use_ra), .use_rb(use_rb));

   register_file u_rf (
      .clk(clk), .rst_n(rst_n), .wb(wb),
      .ra(af.ra), .rb(af.rb), .rd1(rd1), .rd2(rd2)
   );

   hazard_unit u_hazard (
      .clk(clk), .rst_n(rst_n), .ra(af.ra), .rb(af.rb),
      .use_ra(use_ra), .use_rb(use_rb), .dest(ctl.dest),
      .writes(ctl.reg_write), .is_load(ctl.mem_read),
      .stall(stall), .sb(sb)
   );

   forwarding_unit u_fwd (
      .sb(sb), .ra(af.ra), .rb(af.rb), .use_ra(use_ra), .use_rb(use_rb),
      .fwd_a(fwd_a), .fwd_b(fwd_b), .fwd_st(fwd_st)
   );

   always_comb begin
      ex        = ctl;
      ex.rd1    = rd1;
      ex.rd2    = rd2;
      ex.fwd_a  = fwd_a;
      ex.fwd_b  = fwd_b;
      ex.fwd_st = fwd_st;
   end

   // Hold fetch, send a bubble to EX
   assign pc_en      = !stall;
   assign ifid_en    = !stall;
   assign idex_flush = stall;

   a_alu_op_known: assert property (@(posedge clk) disable iff (!rst_n)
      af.major == MAJ_ALU |-> alu_op_defined(af.alu_op))
      else $error("undefined alu_op %h", af.alu_op);

   // Source with a writer in flight is forwarded or stalled
   a_src_covered: assert property (@(posedge clk) disable iff (!rst_n)
      ((use_rb && sb[af.rb].age != AGE_NONE && fwd_a == FWD_NONE) ||
       (use_ra && sb[af.ra].age != AGE_NONE && fwd_b == FWD_NONE)) |-> stall)
      else $error("in-flight source neither forwarded nor stalled");

endmodule

`default_nettype wire

// File: forwarding_unit.sv
`timescale 1ns/10ps
`default_nettype none

module forwarding_unit (
   input  pipe_ctrl_pkg::sb_entry_t [7:0] sb,
   input  cpu_isa_pkg::reg_idx_t          ra,
   input  cpu_isa_pkg::reg_idx_t          rb,
   input  logic                           use_ra,
   input  logic                           use_rb,
   output pipe_ctrl_pkg::fwd_sel_e        fwd_a,
   output pipe_ctrl_pkg::fwd_sel_e        fwd_b,
   output pipe_ctrl_pkg::fwd_sel_e        fwd_st
);
   import pipe_ctrl_pkg::*;

   function automatic fwd_sel_e pick(sb_entry_t e, logic used);
      fwd_sel_e sel;
      sel = FWD_NONE;
      if (used) begin
         if (e.age == AGE_EX && !e.is_load) begin
            sel = FWD_MEM;
         end else if (e.age == AGE_MEM) begin
            sel = FWD_WB;
         end
      end
      return sel;
   endfunction

   assign fwd_a  = pick(sb[rb], use_rb);  // Operand a is rb
   assign fwd_b  = pick(sb[ra], use_ra);
   assign fwd_st = pick(sb[ra], use_ra);  // Store data from ra

endmodule

`default_nettype wire

// File: hazard_unit.sv
`timescale 1ns/10ps
`default_nettype none

module hazard_unit (
   input  logic                                clk,
   input  logic                                rst_n,
   input  cpu_isa_pkg::reg_idx_t               ra,
   input  cpu_isa_pkg::reg_idx_t               rb,
   input  logic                                use_ra,
   input  logic                                use_rb,
   input  cpu_isa_pkg::reg_idx_t               dest,
   input  logic                                writes,
   input  logic                                is_load,
   output logic                                stall,
   output pipe_ctrl_pkg::sb_entry_t [7:0]      sb
);
   import pipe_ctrl_pkg::*;

   logic load_use_a;
   logic load_use_b;

   // Load still in EX, its data is not there yet
   assign load_use_a = use_ra && sb[ra].age == AGE_EX && sb[ra].is_load;
   assign load_use_b = use_rb && sb[rb].age == AGE_EX && sb[rb].is_load;
   assign stall      = load_use_a | load_use_b;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         sb <= '0;
      end else begin
         for (int i = 0; i < 8; i++) begin
            if (sb[i].age == AGE_EX) begin
               sb[i].age <= AGE_MEM;
            end else begin
               sb[i] <= '0;
            end
         end
         if (writes && !stall) begin
            sb[dest].age     <= AGE_EX;  // Youngest writer wins
            sb[dest].is_load <= is_load;
         end
      end
   end

   // A held instruction must issue on its second try
   property p_single_stall;
      @(posedge clk) disable iff (!rst_n)
         stall |=> !(stall && $stable({ra, rb, use_ra, use_rb, dest, writes, is_load}));
   endproperty

   a_single_stall: assert property (p_single_stall)
      else $error("load-use stall held longer than one cycle");

endmodule

`default_nettype wire

// File: register_file.sv
`timescale 1ns/10ps
`default_nettype none

module register_file (
   input  logic                   clk,
   input  logic                   rst_n,
   input  pipe_ctrl_pkg::wb_bus_t wb,
   input  cpu_isa_pkg::reg_idx_t  ra,
   input  cpu_isa_pkg::reg_idx_t  rb,
   output cpu_isa_pkg::word_t     rd1,
   output cpu_isa_pkg::word_t     rd2
);
   import cpu_isa_pkg::*;

   word_t regs [8];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (wb.we) begin
         regs[wb.addr] <= wb.data;
      end
   end

   // Write-through bypass
   assign rd1 = (wb.we && wb.addr == ra) ? wb.data : regs[ra];
   assign rd2 = (wb.we && wb.addr == rb) ? wb.data : regs[rb];

endmodule

`default_nettype wire

// File: id_controller.sv
`timescale 1ns/10ps
`default_nettype none

module id_controller (
   input  cpu_isa_pkg::word_t    inst,
   output pipe_ctrl_pkg::id_ex_t ctl,
   output logic                  use_ra,
   output logic                  use_rb
);
   import cpu_isa_pkg::*;
   import pipe_ctrl_pkg::*;

   alu_fmt_t af;
   mem_fmt_t mf;
   imm_fmt_t imf;

   assign af  = alu_fmt_t'(inst);
   assign mf  = mem_fmt_t'(inst);
   assign imf = imm_fmt_t'(inst);

   always_comb begin
      ctl        = '0;
      ctl.src_a  = SRC_REG;
      ctl.src_b  = SRC_REG;
      ctl.imm    = {{8{mf.imm[7]}}, mf.imm};
      ctl.shamt  = af.d;
      ctl.dest   = mf.rb;
      ctl.wb_sel = WB_NONE;
      use_ra     = 1'b0;
      use_rb     = 1'b0;

      case (mf.major)
         MAJ_LOAD: begin
            ctl.src_b     = SRC_IMM;     // rb + imm
            ctl.dest      = mf.ra;
            ctl.reg_write = 1'b1;
            ctl.mem_read  = 1'b1;
            use_rb        = 1'b1;
         end
         MAJ_STORE: begin
            ctl.src_b     = SRC_IMM;
            ctl.mem_write = 1'b1;
            use_ra        = 1'b1;        // Store data
            use_rb        = 1'b1;        // Base address
         end
         MAJ_IMM: begin
            ctl.src_b = SRC_IMM;
            case (imf.imm_op)
               IOP_LI: begin
                  ctl.src_a     = SRC_ZERO;
                  ctl.reg_write = 1'b1;
               end
               IOP_ADDI: begin
                  ctl.reg_write = 1'b1;
                  use_rb        = 1'b1;
               end
               IOP_SUBI: begin
                  ctl.alu_op    = OP_SUB;
                  ctl.reg_write = 1'b1;
                  use_rb        = 1'b1;
               end
               IOP_CMPI: begin
                  ctl.alu_op = OP_CMP;
                  use_rb     = 1'b1;
               end
               default: ctl.src_a = SRC_ZERO;
            endcase
         end
         MAJ_ALU: begin
            ctl.alu_op = af.alu_op;
            case (af.alu_op)
               OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                  ctl.reg_write = 1'b1;
                  use_ra        = 1'b1;
                  use_rb        = 1'b1;
               end
               OP_CMP: begin
                  use_ra = 1'b1;
                  use_rb = 1'b1;
               end
               OP_MOV: begin
                  ctl.src_a     = SRC_ZERO;  // rb = ra
                  ctl.reg_write = 1'b1;
                  use_ra        = 1'b1;
               end
               OP_SLL, OP_SRL: begin
                  ctl.src_b     = SRC_SHAMT;
                  ctl.reg_write = 1'b1;
                  use_rb        = 1'b1;
               end
               OP_OUT: begin
                  ctl.src_a  = SRC_ZERO;
                  ctl.out_en = 1'b1;
                  use_ra     = 1'b1;
               end
               OP_HLT: begin
                  ctl.src_a = SRC_ZERO;
                  ctl.src_b = SRC_ZERO;
                  ctl.halt  = 1'b1;
               end
               default: begin
                  ctl.src_a = SRC_ZERO;
                  ctl.src_b = SRC_ZERO;
               end
            endcase
         end
      endcase

      if (ctl.reg_write) begin
         ctl.wb_sel = ctl.mem_read ? WB_MEM : WB_ALU;
      end
   end

endmodule

`default_nettype wire

// File: pipe_ctrl_pkg.sv
`default_nettype none

package pipe_ctrl_pkg;

   // ALU operand source
   typedef enum logic [1:0] {
      SRC_REG   = 2'd0,
      SRC_IMM   = 2'd1,
      SRC_SHAMT = 2'd2,
      SRC_ZERO  = 2'd3
   } src_sel_e;

   typedef enum logic [1:0] {
      FWD_NONE = 2'd0,
      FWD_MEM  = 2'd1,     // EX/MEM result
      FWD_WB   = 2'd2      // Write-back data
   } fwd_sel_e;

   typedef enum logic [1:0] {
      WB_ALU  = 2'd0,
      WB_MEM  = 2'd1,
      WB_NONE = 2'd2
   } wb_sel_e;

   // Scoreboard ages
   localparam logic [1:0] AGE_NONE = 2'd0;
   localparam logic [1:0] AGE_EX   = 2'd1;
   localparam logic [1:0] AGE_MEM  = 2'd2;

   typedef struct packed {
      logic                  we;
      cpu_isa_pkg::reg_idx_t addr;
      cpu_isa_pkg::word_t    data;
   } wb_bus_t;

   typedef struct packed {
      logic [1:0] age;
      logic       is_load;
   } sb_entry_t;

   typedef struct packed {
      cpu_isa_pkg::alu_op_e  alu_op;
      src_sel_e              src_a;
      src_sel_e              src_b;
      cpu_isa_pkg::word_t    rd1;
      cpu_isa_pkg::word_t    rd2;
      cpu_isa_pkg::word_t    imm;
      logic [3:0]            shamt;
      cpu_isa_pkg::reg_idx_t dest;
      logic                  reg_write;
      logic                  mem_write;
      logic                  mem_read;
      logic                  out_en;
      logic                  halt;
      wb_sel_e               wb_sel;
      fwd_sel_e              fwd_a;
      fwd_sel_e              fwd_b;
      fwd_sel_e              fwd_st;
   } id_ex_t;

endpackage

`default_nettype wire

// File: cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

   typedef logic [15:0] word_t;
   typedef logic [2:0]  reg_idx_t;

   // Instruction class in bits 15..14
   typedef enum logic [1:0] {
      MAJ_LOAD  = 2'b00,
      MAJ_STORE = 2'b01,
      MAJ_IMM   = 2'b10,
      MAJ_ALU   = 2'b11
   } major_e;

   typedef enum logic [3:0] {
      OP_ADD = 4'h0,
      OP_SUB = 4'h1,
      OP_AND = 4'h2,
      OP_OR  = 4'h3,
      OP_XOR = 4'h4,
      OP_CMP = 4'h5,
      OP_MOV = 4'h6,
      OP_SLL = 4'h8,
      OP_SRL = 4'h9,
      OP_OUT = 4'hd,
      OP_HLT = 4'hf
   } alu_op_e;

   typedef enum logic [2:0] {
      IOP_LI   = 3'd0,
      IOP_ADDI = 3'd1,
      IOP_SUBI = 3'd2,
      IOP_CMPI = 3'd3
   } imm_op_e;

   typedef struct packed {
      major_e     major;
      reg_idx_t   ra;
      reg_idx_t   rb;
      alu_op_e    alu_op;
      logic [3:0] d;       // Shift amount
   } alu_fmt_t;

   // LOAD and STORE layout
   typedef struct packed {
      major_e     major;
      reg_idx_t   ra;
      reg_idx_t   rb;
      logic [7:0] imm;
   } mem_fmt_t;

   typedef struct packed {
      major_e     major;
      imm_op_e    imm_op;
      reg_idx_t   rb;      // Destination
      logic [7:0] imm;
   } imm_fmt_t;

   function automatic logic alu_op_defined(alu_op_e op);
      logic known;
      case (op)
         OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_CMP,
         OP_MOV, OP_SLL, OP_SRL, OP_OUT, OP_HLT: known = 1'b1;
         default: known = 1'b0;
      endcase
      return known;
   endfunction

endpackage

`default_nettype wire
